/* sim.f */
source/lcd_pkg.sv
source/frame_rom.sv
source/frame_sequencer.sv
source/spi_shifter.sv
source/touch_decoder.sv
source/lcd_touch_top.sv
testbench/tb_spi_panel.sv
testbench/tb_lcd_touch.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_lcd_touch
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_lcd_touch.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_touch import lcd_pkg::*; ();

	localparam int CLK_PERIOD = 50;
	localparam int NLOOPS = 6;

	logic clk20MHz;
	logic rst_n;
	logic miso;
	logic sclk;
	logic mosi;
	logic cs_n;
	logic run;
	logic off;
	logic sweep;
	logic lock;
	freq_sel_t freq_cho;
	power_sel_t power;
	touch_capt_t touch_answer;
	int frames_seen;
	frame_len_t rx_len;
	frame_data_t rx_payload;

	logic [31:0] lfsr = 32'hfe7d;
	panel_sel_t model_sel; // Selections the DUT should hold
	int exp_pulses [4]; // RUN, OFF, SWEEP, LOCK
	int seen_pulses [4];
	int errors;
	int checks;
	int frames_checked;
	int reads_seen;
	logic [7:0] tx_mark [$];
	coord_t tx_x [$];
	coord_t tx_y [$];
	string test_names [NLOOPS] = '{"reset and first loop", "mode keys", "frequency keys",
		"power keys", "misses and bad marker", "final loop"};

	lcd_touch_top i_dut (
		.clk20MHz (clk20MHz),
		.rst_n (rst_n),
		.miso (miso),
		.sclk (sclk),
		.mosi (mosi),
		.cs_n (cs_n),
		.run (run),
		.off (off),
		.sweep (sweep),
		.lock (lock),
		.freq_cho (freq_cho),
		.power (power)
	);

	tb_spi_panel i_panel (
		.sclk (sclk),
		.mosi (mosi),
		.cs_n (cs_n),
		.answer (touch_answer),
		.miso (miso),
		.frames_seen (frames_seen),
		.rx_len (rx_len),
		.rx_payload (rx_payload)
	);

	always #(CLK_PERIOD / 2) clk20MHz = ~clk20MHz;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic in_rect(input key_rect_t r, input coord_t x, input coord_t y);
		return x >= r.x_min && x <= r.x_max && y >= r.y_min && y <= r.y_max;
	endfunction

	// 0-3 mode, 4-15 frequency, 16-20 power, -1 no key
	function automatic int key_code(input coord_t x, input coord_t y);
		for (int i = 0; i < N_MODE_KEYS; i++) begin
			if (in_rect(MODE_KEYS[i], x, y)) return i;
		end
		for (int i = 0; i < N_FREQ_KEYS; i++) begin
			if (in_rect(FREQ_KEYS[i], x, y)) return 4 + i;
		end
		for (int i = 0; i < N_POWER_KEYS; i++) begin
			if (in_rect(POWER_KEYS[i], x, y)) return 16 + i;
		end
		return -1;
	endfunction

	// Controller sends each coordinate low byte first
	function automatic touch_capt_t touch_word(input logic [7:0] mark, input coord_t x,
			input coord_t y);
		return {mark, y[7:0], y[15:8], x[7:0], x[15:8]};
	endfunction

	function automatic spi_frame_t expected_frame(input int idx, input panel_sel_t s);
		spi_frame_t f;
		logic lit;
		f.payload = FRAME_WORDS[idx];
		f.nbits = FRAME_LENS[idx];
		f.is_read = (idx >= int'(FIRST_TOUCH_FRAME));
		case (idx)
			6: lit = (s.mode == MODE_RUN);
			7: lit = (s.mode == MODE_OFF);
			8: lit = (s.sweep_mode == SW_SWEEP);
			9: lit = (s.sweep_mode == SW_LOCK);
			default: lit = (idx >= 10 && idx <= 21 && s.freq == freq_sel_t'(idx - 9));
		endcase
		if (idx == 22) begin
			f.payload = POWER_WORDS[s.power];
		end else if (idx >= 6 && idx <= 21) begin
			f.payload[COLOR_LSB +: 24] = lit ? HILITE_COLOR : PLAIN_COLOR;
		end
		return f;
	endfunction

	function automatic int loop_cycles();
		int sum;
		sum = FRAME_COUNT * FRAME_GAP;
		for (int i = 0; i < FRAME_COUNT; i++) begin
			sum += int'(FRAME_LENS[i]) * SCLK_DIV;
		end
		return sum;
	endfunction

	task automatic check_value(input string name, input logic [FRAME_W-1:0] got,
			input logic [FRAME_W-1:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic add_touch(input logic [7:0] mark, input coord_t x, input coord_t y);
		tx_mark.push_back(mark);
		tx_x.push_back(x);
		tx_y.push_back(y);
	endtask

	task automatic add_inside(input key_rect_t r, input logic [7:0] mark);
		int w;
		int h;
		w = int'(r.x_max) - int'(r.x_min) + 1;
		h = int'(r.y_max) - int'(r.y_min) + 1;
		add_touch(mark, coord_t'(int'(r.x_min) + int'(rand_bits(16)) % w),
			coord_t'(int'(r.y_min) + int'(rand_bits(16)) % h));
	endtask

	task automatic add_outside();
		coord_t x;
		coord_t y;
		do begin
			x = coord_t'(rand_bits(10));
			y = coord_t'(rand_bits(10));
		end while (key_code(x, y) >= 0);
		add_touch(TOUCH_MARK, x, y);
	endtask

	// What the decoder should do with read number r
	task automatic apply_touch(input int r);
		int code;
		if (tx_mark[r] == TOUCH_MARK) begin
			code = key_code(tx_x[r], tx_y[r]);
			if (code >= 0 && code < 4) begin
				exp_pulses[code]++;
				case (code)
					0: model_sel.mode = MODE_RUN;
					1: model_sel.mode = MODE_OFF;
					2: model_sel.sweep_mode = SW_SWEEP;
					default: model_sel.sweep_mode = SW_LOCK;
				endcase
			end else if (code >= 4 && code < 16) begin
				model_sel.freq = freq_sel_t'(code - 3);
			end else if (code >= 16) begin
				model_sel.power = power_sel_t'(code - 16);
			end
		end
	endtask

	task automatic check_outputs();
		check_value("freq_cho", freq_cho, model_sel.freq);
		check_value("power", power, model_sel.power);
		check_value("run pulse count", seen_pulses[0], exp_pulses[0]);
		check_value("off pulse count", seen_pulses[1], exp_pulses[1]);
		check_value("sweep pulse count", seen_pulses[2], exp_pulses[2]);
		check_value("lock pulse count", seen_pulses[3], exp_pulses[3]);
	endtask

	// Pulses are sampled mid-cycle where they are stable
	always @(negedge clk20MHz) begin
		if (run) seen_pulses[0] = seen_pulses[0] + 1;
		if (off) seen_pulses[1] = seen_pulses[1] + 1;
		if (sweep) seen_pulses[2] = seen_pulses[2] + 1;
		if (lock) seen_pulses[3] = seen_pulses[3] + 1;
	end

	initial begin
		clk20MHz = 1'b0;
		rst_n = 1'b0;
		model_sel = '0;
		errors = 0;
		checks = 0;
		frames_checked = 0;
		reads_seen = 0;
		for (int i = 0; i < 4; i++) begin
			exp_pulses[i] = 0;
			seen_pulses[i] = 0;
		end
		repeat (6) add_outside();
		for (int i = 0; i < 6; i++) begin
			add_inside(MODE_KEYS[i % N_MODE_KEYS], TOUCH_MARK);
		end
		repeat (6) add_inside(FREQ_KEYS[int'(rand_bits(8)) % N_FREQ_KEYS], TOUCH_MARK);
		repeat (6) add_inside(POWER_KEYS[int'(rand_bits(8)) % N_POWER_KEYS], TOUCH_MARK);
		repeat (3) add_outside();
		add_inside(MODE_KEYS[int'(rand_bits(2))], TOUCH_MARK ^ (8'h01 | 8'(rand_bits(8))));
		add_inside(FREQ_KEYS[int'(rand_bits(8)) % N_FREQ_KEYS], TOUCH_MARK ^ 8'h80);
		add_inside(POWER_KEYS[int'(rand_bits(8)) % N_POWER_KEYS], 8'h00);
		repeat (6) add_outside();
		touch_answer = touch_word(tx_mark[0], tx_x[0], tx_y[0]);
		repeat (3) @(posedge clk20MHz);
		#5;
		check_value("cs_n", cs_n, 1'b1);
		check_value("sclk", sclk, 1'b0);
		check_value("mosi", mosi, 1'b0);
		check_value("run", run, 1'b0);
		check_value("off", off, 1'b0);
		check_value("sweep", sweep, 1'b0);
		check_value("lock", lock, 1'b0);
		check_outputs();
		rst_n = 1'b1;
		// Next answer goes in once the previous read has been seen
		for (int r = 1; r < tx_mark.size(); r++) begin
			while (reads_seen < r) begin
				@(posedge clk20MHz);
				#5;
			end
			touch_answer = touch_word(tx_mark[r], tx_x[r], tx_y[r]);
		end
		wait (frames_checked == NLOOPS * FRAME_COUNT);
		repeat (20) @(posedge clk20MHz);
		check_outputs();
		$display("%0d tests, %0d checks, %0d errors", NLOOPS, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : compare_frames
		spi_frame_t want;
		int idx;
		int loop_errors;
		loop_errors = 0;
		wait (rst_n);
		forever begin
			@(negedge clk20MHz);
			if (frames_seen != frames_checked) begin
				idx = frames_checked % FRAME_COUNT;
				want = expected_frame(idx, model_sel);
				check_value($sformatf("frame %0d length", idx), rx_len, want.nbits);
				check_value($sformatf("frame %0d payload", idx), rx_payload, want.payload);
				check_outputs(); // Effects of the previous read have settled
				if (want.is_read) begin
					apply_touch(reads_seen);
					reads_seen++;
				end
				frames_checked++;
				if (idx == FRAME_COUNT - 1) begin
					$display("test %0d %s: %0d errors", frames_checked / FRAME_COUNT - 1,
						test_names[frames_checked / FRAME_COUNT - 1], errors - loop_errors);
					loop_errors = errors;
				end
			end
		end
	end

	// Counts clock samples of each cs_n level
	initial begin : measure_cs
		int run_len;
		int n_low;
		logic prev;
		wait (rst_n);
		prev = 1'b1;
		run_len = 0;
		n_low = 0;
		forever begin
			@(negedge clk20MHz);
			if (cs_n !== prev) begin
				if (prev == 1'b0) begin
					check_value("cs_n low cycles", run_len,
						int'(FRAME_LENS[n_low % FRAME_COUNT]) * SCLK_DIV);
					n_low++;
				end else if (n_low > 0) begin
					check_value("cs_n high cycles", run_len, FRAME_GAP);
				end
				run_len = 0;
				prev = cs_n;
			end
			run_len++;
		end
	end

	initial begin : watchdog
		longint limit_ns;
		limit_ns = longint'(NLOOPS * loop_cycles() + 200) * CLK_PERIOD * 2;
		#(limit_ns);
		$display("Watchdog expired with %0d of %0d frames received", frames_seen,
			NLOOPS * FRAME_COUNT);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_spi_panel.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_panel import lcd_pkg::*; (
	input logic sclk,
	input logic mosi,
	input logic cs_n,
	input touch_capt_t answer, // Marker, Y and X in the order they go out
	output logic miso,
	output int frames_seen,
	output frame_len_t rx_len,
	output frame_data_t rx_payload
);

	localparam logic [7:0] RD_CMD = 8'h30; // First byte of a touch read
	localparam int ANS_FIRST = 24; // Command, address and dummy come first

	frame_data_t sr;
	int nbits;
	logic [7:0] cmd;

	initial begin
		miso = 1'b0;
		frames_seen = 0;
		rx_len = '0;
		rx_payload = '0;
		sr = '0;
		nbits = 0;
		cmd = '0;
	end

	// The first bit and the first rising sclk leave the DUT on the same edge
	always @(posedge sclk) begin
		#1;
		sr = {sr[FRAME_W-2:0], mosi};
		nbits = nbits + 1;
		if (nbits == 8) begin
			cmd = sr[7:0];
		end
	end

	// Answer bits change while sclk is low
	always @(negedge sclk) begin
		if (cmd == RD_CMD && nbits >= ANS_FIRST && nbits < ANS_FIRST + TOUCH_CAPT_W) begin
			miso = answer[ANS_FIRST + TOUCH_CAPT_W - 1 - nbits];
		end else begin
			miso = 1'b0;
		end
	end

	// A rise of cs_n with no bits is the DUT leaving reset
	always @(posedge cs_n) begin
		if (nbits > 0) begin
			rx_len = frame_len_t'(nbits);
			rx_payload = sr << (FRAME_W - nbits); // Left aligned like the frame tables
			frames_seen = frames_seen + 1;
		end
		nbits = 0;
		cmd = '0;
		sr = '0;
		miso = 1'b0;
	end

endmodule

`default_nettype wire

/* source/lcd_touch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_touch_top import lcd_pkg::*; (
	input logic clk20MHz,
	input logic rst_n,
	input logic miso,
	output logic sclk,
	output logic mosi,
	output logic cs_n,
	output logic run,
	output logic off,
	output logic sweep,
	output logic lock,
	output freq_sel_t freq_cho,
	output power_sel_t power
);

	frame_idx_t frame_idx;
	spi_frame_t rom_frame; // Combinational lookup
	spi_frame_t tx_frame; // Latched at start
	logic start;
	logic done;
	logic capt_valid;
	touch_capt_t capt;
	panel_sel_t sel; // Fed back into the frame contents

	frame_sequencer i_sequencer (
		.clk20MHz (clk20MHz),
		.rst_n (rst_n),
		.frame_in (rom_frame),
		.done (done),
		.frame_idx (frame_idx),
		.start (start),
		.frame (tx_frame)
	);

	frame_rom i_rom (
		.frame_idx (frame_idx),
		.sel (sel),
		.frame (rom_frame)
	);

	spi_shifter i_shifter (
		.clk20MHz (clk20MHz),
		.rst_n (rst_n),
		.start (start),
		.frame (tx_frame),
		.miso (miso),
		.sclk (sclk),
		.mosi (mosi),
		.cs_n (cs_n),
		.done (done),
		.capt_valid (capt_valid),
		.capt (capt)
	);

	touch_decoder i_decoder (
		.clk20MHz (clk20MHz),
		.rst_n (rst_n),
		.capt_valid (capt_valid),
		.capt (capt),
		.sel (sel),
		.run (run),
		.off (off),
		.sweep (sweep),
		.lock (lock),
		.freq_cho (freq_cho),
		.power (power)
	);

endmodule

`default_nettype wire

/* source/touch_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module touch_decoder import lcd_pkg::*; (
	input logic clk20MHz,
	input logic rst_n,
	input logic capt_valid,
	input touch_capt_t capt,
	output panel_sel_t sel,
	output logic run,
	output logic off,
	output logic sweep,
	output logic lock,
	output freq_sel_t freq_cho,
	output power_sel_t power
);

	touch_xy_t pt;
	logic mode_hit;
	logic [1:0] mode_key; // RUN, OFF, SWEEP, LOCK
	logic freq_hit;
	freq_sel_t freq_key;
	logic power_hit;
	power_sel_t power_key;

	function automatic logic in_key(input key_rect_t r, input touch_xy_t p);
		return (p.x >= r.x_min) && (p.x <= r.x_max) && (p.y >= r.y_min) && (p.y <= r.y_max);
	endfunction

	// Controller returns each coordinate low byte first
	assign pt = {capt[39:32], capt[23:16], capt[31:24], capt[7:0], capt[15:8]};

	// Downward loops leave the lowest matching key
	always_comb begin
		mode_hit = 1'b0;
		mode_key = '0;
		freq_hit = 1'b0;
		freq_key = '0;
		power_hit = 1'b0;
		power_key = '0;
		for (int i = N_MODE_KEYS - 1; i >= 0; i--) begin
			if (in_key(MODE_KEYS[i], pt)) begin
				mode_hit = 1'b1;
				mode_key = 2'(i);
			end
		end
		for (int i = N_FREQ_KEYS - 1; i >= 0; i--) begin
			if (in_key(FREQ_KEYS[i], pt)) begin
				freq_hit = 1'b1;
				freq_key = freq_sel_t'(i + 1); // 0 is kept for no selection
			end
		end
		for (int i = N_POWER_KEYS - 1; i >= 0; i--) begin
			if (in_key(POWER_KEYS[i], pt)) begin
				power_hit = 1'b1;
				power_key = power_sel_t'(i);
			end
		end
	end

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			sel <= '{MODE_NONE, SW_NONE, '0, '0};
			run <= 1'b0;
			off <= 1'b0;
			sweep <= 1'b0;
			lock <= 1'b0;
		end else begin
			run <= 1'b0;
			off <= 1'b0;
			sweep <= 1'b0;
			lock <= 1'b0;
			if (capt_valid && pt.mark == TOUCH_MARK) begin
				if (mode_hit) begin
					case (mode_key)
						2'd0: begin
							run <= 1'b1;
							sel.mode <= MODE_RUN;
						end
						2'd1: begin
							off <= 1'b1;
							sel.mode <= MODE_OFF;
						end
						2'd2: begin
							sweep <= 1'b1;
							sel.sweep_mode <= SW_SWEEP;
						end
						default: begin
							lock <= 1'b1;
							sel.sweep_mode <= SW_LOCK;
						end
					endcase
				end else if (freq_hit) begin
					sel.freq <= freq_key;
				end else if (power_hit) begin
					sel.power <= power_key;
				end
			end
		end
	end

	assign freq_cho = sel.freq;
	assign power = sel.power;

endmodule

`default_nettype wire

/* source/spi_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_shifter import lcd_pkg::*; (
	input logic clk20MHz,
	input logic rst_n,
	input logic start,
	input spi_frame_t frame,
	input logic miso,
	output logic sclk,
	output logic mosi,
	output logic cs_n,
	output logic done,
	output logic capt_valid,
	output touch_capt_t capt
);

	seq_state_t state;
	frame_data_t tx_sr; // Next bit to send at the MSB
	touch_capt_t rx_sr;
	frame_len_t bits_left; // Bits after the current one
	div_cnt_t div_cnt;
	gap_cnt_t gap_cnt;
	logic is_read;
	logic sclk_fall;
	logic bit_end;

	assign sclk_fall = (state == S_SEND) && (div_cnt == div_cnt_t'(SCLK_DIV / 2 - 1));
	assign bit_end = (state == S_SEND) && (div_cnt == div_cnt_t'(SCLK_DIV - 1));
	assign capt = rx_sr; // Stable from the end of the frame to the next start

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			sclk <= 1'b0;
			mosi <= 1'b0;
			cs_n <= 1'b1;
			done <= 1'b0;
			capt_valid <= 1'b0;
			bits_left <= '0;
			div_cnt <= '0;
			gap_cnt <= '0;
			is_read <= 1'b0;
		end else begin
			done <= 1'b0;
			capt_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						cs_n <= 1'b0;
						sclk <= 1'b1; // Bit period opens high
						mosi <= frame.payload[FRAME_W-1];
						bits_left <= frame.nbits - 1'b1;
						div_cnt <= '0;
						is_read <= frame.is_read;
						state <= S_SEND;
					end
				end
				S_SEND: begin
					div_cnt <= div_cnt + 1'b1;
					if (sclk_fall) begin
						sclk <= 1'b0;
						mosi <= (bits_left == '0) ? 1'b0 : tx_sr[FRAME_W-1];
					end
					if (bit_end) begin
						if (bits_left == '0) begin
							cs_n <= 1'b1;
							gap_cnt <= '0;
							state <= S_GAP;
						end else begin
							sclk <= 1'b1;
							div_cnt <= '0;
							bits_left <= bits_left - 1'b1;
						end
					end
				end
				S_GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					// Start and reload take the last two cycles of the gap
					if (gap_cnt == gap_cnt_t'(FRAME_GAP - 3)) begin
						done <= 1'b1;
						capt_valid <= is_read;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (state == S_IDLE && start) begin
			tx_sr <= frame.payload << 1; // MSB already on mosi
		end else if (sclk_fall) begin
			tx_sr <= tx_sr << 1;
		end
		if (state == S_SEND && div_cnt == '0) begin
			rx_sr <= {rx_sr[TOUCH_CAPT_W-2:0], miso}; // First clock with sclk high
		end
	end

endmodule

`default_nettype wire

/* source/frame_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer import lcd_pkg::*; (
	input logic clk20MHz,
	input logic rst_n,
	input spi_frame_t frame_in,
	input logic done,
	output frame_idx_t frame_idx,
	output logic start,
	output spi_frame_t frame
);

	seq_state_t state;
	frame_idx_t next_idx;
	logic issue; // Latch the looked-up frame and start it

	// List loops forever
	assign next_idx = (frame_idx == frame_idx_t'(FRAME_COUNT - 1)) ? '0 : frame_idx + 1'b1;

	// Back to back with the shifter, next start right after done
	assign issue = (state == S_LOAD) || (state == S_SEND && done);

	always_ff @(posedge clk20MHz or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_LOAD; // Frame 0 goes out right after reset
			frame_idx <= '0;
			start <= 1'b0;
		end else begin
			start <= issue;
			if (issue) begin
				frame_idx <= next_idx; // ROM looks ahead during the transfer
				state <= S_SEND;
			end
		end
	end

	// Holds the frame steady for the shifter
	always_ff @(posedge clk20MHz) begin
		if (issue) begin
			frame <= frame_in;
		end
	end

endmodule

`default_nettype wire

/* source/frame_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_rom import lcd_pkg::*; (
	input frame_idx_t frame_idx,
	input panel_sel_t sel,
	output spi_frame_t frame
);

	logic has_color; // Frame carries a key colour
	logic hilite; // Key of this frame is selected

	always_comb begin
		has_color = 1'b0;
		hilite = 1'b0;
		if (frame_idx >= MODE_FRAME && frame_idx < FREQ_FRAME) begin
			has_color = 1'b1;
			case (frame_idx - MODE_FRAME)
				5'd0: hilite = (sel.mode == MODE_RUN);
				5'd1: hilite = (sel.mode == MODE_OFF);
				5'd2: hilite = (sel.sweep_mode == SW_SWEEP);
				default: hilite = (sel.sweep_mode == SW_LOCK);
			endcase
		end else if (frame_idx >= FREQ_FRAME && frame_idx < POWER_FRAME) begin
			has_color = 1'b1;
			// Key n lives in frame FREQ_FRAME + n - 1
			hilite = ({1'b0, sel.freq} == frame_idx - FREQ_FRAME + 5'd1);
		end
	end

	always_comb begin
		frame.payload = FRAME_WORDS[frame_idx];
		frame.nbits = FRAME_LENS[frame_idx];
		frame.is_read = (frame_idx >= FIRST_TOUCH_FRAME); // Touch XY polls
		if (frame_idx == POWER_FRAME) begin
			frame.payload = POWER_WORDS[sel.power]; // Bar drawn for the level
		end else if (has_color) begin
			frame.payload[COLOR_LSB +: $bits(color_t)] = hilite ? HILITE_COLOR : PLAIN_COLOR;
		end
	end

endmodule

`default_nettype wire

/* source/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	localparam int FRAME_W = 152; // Widest frame, first bit out is the MSB
	localparam int FRAME_COUNT = 30; // Frames in one loop
	localparam int SCLK_DIV = 8; // clk20MHz cycles per sclk period
	localparam int FRAME_GAP = 16; // cs_n high cycles between frames
	localparam int TOUCH_CAPT_W = 40; // Marker byte plus two coordinates
	localparam int COLOR_LSB = 120; // Colour field in a display-list frame
	localparam int N_MODE_KEYS = 4;
	localparam int N_FREQ_KEYS = 12;
	localparam int N_POWER_KEYS = 5;

	typedef logic [FRAME_W-1:0] frame_data_t;
	typedef logic [7:0] frame_len_t;
	typedef logic [4:0] frame_idx_t;
	typedef logic [15:0] coord_t;
	typedef logic [23:0] color_t;
	typedef logic [TOUCH_CAPT_W-1:0] touch_capt_t;
	typedef logic [3:0] freq_sel_t; // 0 none, 1 to 12 for 30 kHz to 41 kHz
	typedef logic [2:0] power_sel_t; // Levels 0 to 4
	typedef logic [$clog2(SCLK_DIV)-1:0] div_cnt_t;
	typedef logic [$clog2(FRAME_GAP)-1:0] gap_cnt_t;

	localparam logic [7:0] TOUCH_MARK = 8'h42;
	localparam frame_idx_t MODE_FRAME = 5'd6; // RUN, OFF, SWEEP, LOCK buttons
	localparam frame_idx_t FREQ_FRAME = 5'd10; // First frequency key
	localparam frame_idx_t POWER_FRAME = 5'd22;
	localparam frame_idx_t FIRST_TOUCH_FRAME = 5'd24;
	localparam color_t HILITE_COLOR = 24'h0000FF;
	localparam color_t PLAIN_COLOR = 24'hFFFFFF;

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_SEND, S_GAP} seq_state_t;
	typedef enum logic [1:0] {MODE_NONE, MODE_RUN, MODE_OFF} mode_t;
	typedef enum logic [1:0] {SW_NONE, SW_SWEEP, SW_LOCK} sweep_mode_t;

	typedef struct packed {
		frame_data_t payload;
		frame_len_t nbits;
		logic is_read;
	} spi_frame_t;

	// Coordinates already in host byte order
	typedef struct packed {
		logic [7:0] mark;
		coord_t y;
		coord_t x;
	} touch_xy_t;

	typedef struct packed {
		mode_t mode;
		sweep_mode_t sweep_mode;
		freq_sel_t freq;
		power_sel_t power;
	} panel_sel_t;

	typedef struct packed {
		coord_t x_min;
		coord_t x_max;
		coord_t y_min;
		coord_t y_max;
	} key_rect_t;

	localparam key_rect_t MODE_KEYS [N_MODE_KEYS] = '{
		'{16'd84, 16'd210, 16'd768, 16'd871}, // RUN
		'{16'd75, 16'd210, 16'd545, 16'd643}, // OFF
		'{16'd75, 16'd210, 16'd312, 16'd415}, // SWEEP
		'{16'd75, 16'd210, 16'd84, 16'd187} // LOCK
	};

	localparam key_rect_t FREQ_KEYS [N_FREQ_KEYS] = '{
		'{16'd311, 16'd348, 16'd0, 16'd730}, // 30 kHz
		'{16'd372, 16'd412, 16'd0, 16'd730},
		'{16'd432, 16'd468, 16'd0, 16'd730},
		'{16'd492, 16'd523, 16'd0, 16'd730},
		'{16'd553, 16'd587, 16'd0, 16'd730},
		'{16'd616, 16'd652, 16'd0, 16'd730},
		'{16'd670, 16'd707, 16'd0, 16'd730},
		'{16'd736, 16'd768, 16'd0, 16'd730},
		'{16'd791, 16'd816, 16'd0, 16'd730},
		'{16'd848, 16'd880, 16'd0, 16'd730},
		'{16'd909, 16'd940, 16'd0, 16'd730},
		'{16'd962, 16'd1000, 16'd0, 16'd730} // 41 kHz
	};

	localparam key_rect_t POWER_KEYS [N_POWER_KEYS] = '{
		'{16'd488, 16'd568, 16'd776, 16'd895},
		'{16'd620, 16'd681, 16'd776, 16'd895},
		'{16'd718, 16'd781, 16'd776, 16'd895},
		'{16'd802, 16'd860, 16'd776, 16'd895},
		'{16'd887, 16'd947, 16'd776, 16'd895}
	};

	// Bar length grows with the level
	localparam frame_data_t POWER_WORDS [N_POWER_KEYS] = '{
		{8'hB0, PLAIN_COLOR, 16'h0238, 104'h045000000E4003084DD004584D},
		{8'hB0, PLAIN_COLOR, 16'h0238, 104'h045000000E4003704FD004C04F},
		{8'hB0, PLAIN_COLOR, 16'h0238, 104'h045000000E4003D851D0042852},
		{8'hB0, PLAIN_COLOR, 16'h0238, 104'h045000000E40034054D0049054},
		{8'hB0, PLAIN_COLOR, 16'h0238, 104'h045000000E4003A856D004F856}
	};

	// Left aligned, padding below the last bit is zero
	localparam frame_data_t FRAME_WORDS [FRAME_COUNT] = '{
		{24'h000000, 128'h0}, // ACTIVE
		{24'h440000, 128'h0}, // CLKEXT
		{40'hB0202CA003, 112'h0}, // HCYCLE
		{40'hB020305800, 112'h0}, // HOFFSET
		{40'hB0203C3000, 112'h0}, // HSYNC1
		{40'hB020400D02, 112'h0}, // VCYCLE
		{8'hB0, PLAIN_COLOR, 16'h00F0, 104'h045000000E0000C28300004790},
		{8'hB0, PLAIN_COLOR, 16'h0100, 104'h045000000E0009F040000E1044},
		{8'hB0, PLAIN_COLOR, 16'h0110, 104'h045000000E0000D08300005590},
		{8'hB0, PLAIN_COLOR, 16'h0120, 104'h045000000E0000D78300005C90},
		{8'hB0, PLAIN_COLOR, 16'h0008, 104'h04335BDC9C305B1C9E6B5B5C9F},
		{8'hB0, PLAIN_COLOR, 16'h0018, 104'h04335B1CA3315B5CA46B5B9CA5},
		{8'hB0, PLAIN_COLOR, 16'h0028, 104'h04335B5CA9325B9CAA6B5BDCAB},
		{8'hB0, PLAIN_COLOR, 16'h0038, 104'h04335B9CAF335BDCB06B5B1CB2},
		{8'hB0, PLAIN_COLOR, 16'h0048, 104'h04335BDCB5345B1CB76B5B5CB8},
		{8'hB0, PLAIN_COLOR, 16'h0058, 104'h04335B1CBC355B5CBD6B5B9CBE},
		{8'hB0, PLAIN_COLOR, 16'h0074, 104'h04335B1C80365B5C816B5B9C82},
		{8'hB0, PLAIN_COLOR, 16'h0084, 104'h04335B5C86375B9C876B5BDC88},
		{8'hB0, PLAIN_COLOR, 16'h0094, 104'h04335B9C8C385BDC8D6B5B1C8F},
		{8'hB0, PLAIN_COLOR, 16'h00A4, 104'h04335BDC92395B1C946B5B5C95},
		{8'hB0, PLAIN_COLOR, 16'h00B4, 104'h04345B1C99305B5C9A6B5B9C9B},
		{8'hB0, PLAIN_COLOR, 16'h00C4, 104'h04345B5C9F315B9CA06B5BDCA1},
		POWER_WORDS[0],
		{32'hB0205402, 120'h0}, // DLSWAP
		{64'h3021240000000000, 88'h0}, // Touch XY reads
		{64'h3021240000000000, 88'h0},
		{64'h3021240000000000, 88'h0},
		{64'h3021240000000000, 88'h0},
		{64'h3021240000000000, 88'h0},
		{64'h3021240000000000, 88'h0}
	};

	localparam frame_len_t FRAME_LENS [FRAME_COUNT] = '{
		8'd24, 8'd24, 8'd40, 8'd40, 8'd40, 8'd40,
		8'd152, 8'd152, 8'd152, 8'd152,
		8'd152, 8'd152, 8'd152, 8'd152, 8'd152, 8'd152,
		8'd152, 8'd152, 8'd152, 8'd152, 8'd152, 8'd152,
		8'd152, 8'd32,
		8'd64, 8'd64, 8'd64, 8'd64, 8'd64, 8'd64
	};

endpackage

`default_nettype wire
